// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_ocs_controller
FILELIST  := build.f
BUILD_DIR := obj_dir

SIM       := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

// ==== build.f ====
logic/ocs_pkg.sv
logic/ocs_slot_timer.sv
logic/ocs_slot_frame_tx.sv
logic/ocs_controller.sv
dv/tb_clock_gen.sv
dv/tb_ocs_controller.sv

// ==== dv/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen (
    output logic o_clk,
    output logic o_reset
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES = 3;

    initial begin
        o_clk = 1'b0;
        forever #50 o_clk = ~o_clk;
    end

    // Reset released on a falling edge
    initial begin
        o_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_reset = 1'b0;
    end

endmodule

`default_nettype wire

// ==== dv/tb_ocs_controller.sv ====
`default_nettype none

module tb_ocs_controller;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int                  CHANNELS     = 8;
    localparam ocs_pkg::cycle_cnt_t SLOT_LEN     = 32'd40;
    localparam ocs_pkg::cycle_cnt_t CONFIG_DELAY = 32'd10;
    localparam int                  SLOT_PERIOD  = int'(SLOT_LEN + CONFIG_DELAY);

    logic                                clk;
    logic                                reset;
    logic                 [CHANNELS-1:0] chnl_ready;
    logic                 [CHANNELS-1:0] tx_ready;
    logic                 [CHANNELS-1:0] tx_valid;
    ocs_pkg::axis_beat_t  [CHANNELS-1:0] tx_beat;
    logic                                slot_start;
    ocs_pkg::slot_id_t                   slot_id;

    logic                 rand_ready_en;
    ocs_pkg::slot_event_t exp_q [CHANNELS][$];
    int                   frames_done [CHANNELS];
    int                   start_cnt;
    bit                   link_broken;
    int                   up_cnt;
    int                   since_start;
    ocs_pkg::slot_id_t    last_slot;

    tb_clock_gen u_clock_gen (
        .o_clk   (clk),
        .o_reset (reset)
    );

    ocs_controller #(
        .P_CHANNEL_NUM  (CHANNELS),
        .P_SLOT_LEN     (SLOT_LEN),
        .P_CONFIG_DELAY (CONFIG_DELAY)
    ) u_ocs_controller (
        .i_clk        (clk),
        .i_reset      (reset),
        .i_chnl_ready (chnl_ready),
        .o_tx_valid   (tx_valid),
        .o_tx_beat    (tx_beat),
        .i_tx_ready   (tx_ready),
        .o_slot_start (slot_start),
        .o_slot_id    (slot_id)
    );

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped at the first failed check");
    endtask

    // Expected beat straight from the frame layout
    function automatic ocs_pkg::axis_beat_t expected_beat(input int chan,
            input ocs_pkg::frame_kind_e kind, input ocs_pkg::slot_id_t slot, input int beat);
        ocs_pkg::axis_beat_t b;
        ocs_pkg::mac_t       dest;
        dest       = ocs_pkg::TOR_MAC_BASE;
        dest[15:8] = chan[7:0];
        b.keep     = 8'hFF;
        b.last     = (beat == ocs_pkg::FRAME_BEATS - 1);
        case (beat)
            0:       b.data = {dest, ocs_pkg::CTRL_MAC[47:32]};
            1:       b.data = {ocs_pkg::CTRL_MAC[31:0], ocs_pkg::SLOT_ETHER_TYPE, slot, kind};
            default: b.data = 64'h0;
        endcase
        return b;
    endfunction

    //////////////////////////////////////////////////
    // Slot start checks and expected events

    always @(posedge clk) begin : b_slot_check
        ocs_pkg::slot_event_t ev;
        if (reset) begin
            link_broken = 1'b1;
            up_cnt      = 0;
            since_start = 0;
            start_cnt   = 0;
            last_slot   = '0;
        end else begin
            since_start++;
            if (slot_start) begin
                if (link_broken) begin
                    assert (up_cnt == 1) else
                        report_failure("slot start did not follow link-up by one cycle");
                    ev.kind    = ocs_pkg::KIND_START;
                    ev.slot_id = '0;
                end else begin
                    assert (since_start == SLOT_PERIOD) else report_failure($sformatf(
                        "[FAIL] o_slot_start gap got %h expected %h", since_start, SLOT_PERIOD));
                    ev.kind    = ocs_pkg::KIND_SYNC;
                    ev.slot_id = last_slot + 8'd1;
                end
                assert (slot_id == ev.slot_id) else report_failure($sformatf(
                    "[FAIL] o_slot_id got %h expected %h", slot_id, ev.slot_id));
                for (int c = 0; c < CHANNELS; c++) begin
                    exp_q[c].push_back(ev);
                end
                last_slot   = ev.slot_id;
                link_broken = 1'b0;
                since_start = 0;
                start_cnt++;
            end
            if (!(&chnl_ready)) begin
                link_broken = 1'b1;
                up_cnt      = 0;
            end else begin
                up_cnt++;
            end
        end
    end

    //////////////////////////////////////////////////
    // Per-channel frame monitors

    for (genvar c = 0; c < CHANNELS; c++) begin : g_mon
        int beat_cnt;

        always @(posedge clk) begin : b_monitor
            ocs_pkg::axis_beat_t exp_beat;
            if (reset) begin
                beat_cnt       = 0;
                frames_done[c] = 0;
                exp_q[c].delete();
            end else if (tx_valid[c] && tx_ready[c]) begin
                if (exp_q[c].size() == 0) begin
                    report_failure($sformatf("channel %0d sent a beat with no slot event", c));
                end else begin
                    exp_beat = expected_beat(c, exp_q[c][0].kind, exp_q[c][0].slot_id, beat_cnt);
                    assert (tx_beat[c] == exp_beat) else report_failure($sformatf(
                        "[FAIL] o_tx_beat[%0d] got %h expected %h", c, tx_beat[c], exp_beat));
                    if (beat_cnt == ocs_pkg::FRAME_BEATS - 1) begin
                        void'(exp_q[c].pop_front());
                        frames_done[c]++;
                        beat_cnt = 0;
                    end else begin
                        beat_cnt++;
                    end
                end
            end
        end
    end

    // Stream back-pressure
    initial begin : b_ready_drive
        logic [31:0] rnd;
        void'($urandom(32'hc548));
        tx_ready = '1;
        forever begin
            @(negedge clk);
            rnd      = $urandom();
            tx_ready = rand_ready_en ? rnd[CHANNELS-1:0] : '1;
        end
    end

    //////////////////////////////////////////////////
    // Waits and stimulus

    function automatic bit frames_reached(input int target);
        bit ok;
        ok = 1'b1;
        for (int c = 0; c < CHANNELS; c++) begin
            if (frames_done[c] < target) ok = 1'b0;
        end
        return ok;
    endfunction

    task automatic wait_for_starts(input int target, input int limit);
        int i;
        i = 0;
        while (start_cnt < target && i < limit) begin
            @(negedge clk);
            i++;
        end
        if (start_cnt < target) report_failure("timed out waiting for a slot start");
    endtask

    task automatic wait_for_frames(input int target, input int limit);
        int i;
        i = 0;
        while (!frames_reached(target) && i < limit) begin
            @(negedge clk);
            i++;
        end
        if (!frames_reached(target)) report_failure("timed out waiting for frames to finish");
    endtask

    task automatic check_quiet(input int cycles, input bit check_valid);
        repeat (cycles) begin
            @(negedge clk);
            assert (!slot_start) else report_failure($sformatf(
                "[FAIL] o_slot_start got %h expected %h", slot_start, 1'b0));
            assert (!check_valid || tx_valid == '0) else report_failure($sformatf(
                "[FAIL] o_tx_valid got %h expected %h", tx_valid, 8'h00));
        end
    endtask

    initial begin : b_main
        int  i;
        bit  all_done;
        chnl_ready    = '0;
        rand_ready_en = 1'b0;
        i = 0;
        while (reset !== 1'b0 && i < 20) begin
            @(negedge clk);
            i++;
        end
        if (reset !== 1'b0) report_failure("reset was never released");

        // Some links still down
        @(negedge clk);
        chnl_ready = 8'h5F;
        check_quiet(200, 1'b1);

        // Start frame on every link
        chnl_ready = '1;
        wait_for_starts(1, 10);
        wait_for_frames(1, 20);
        // Each link idles after its one start frame
        for (int c = 0; c < CHANNELS; c++) begin
            assert (!tx_valid[c]) else report_failure($sformatf(
                "[FAIL] o_tx_valid[%0d] got %h expected %h", c, tx_valid[c], 1'b0));
        end

        wait_for_starts(7, 7 * SLOT_PERIOD);
        wait_for_frames(7, 20);
        assert (slot_id == 8'h06) else report_failure($sformatf(
            "[FAIL] o_slot_id got %h expected %h", slot_id, 8'h06));

        rand_ready_en = 1'b1;
        wait_for_starts(11, 4 * SLOT_PERIOD + 10);
        wait_for_frames(11, SLOT_PERIOD);

        // Drop link 3 while a frame is on the wire
        wait_for_starts(12, SLOT_PERIOD + 10);
        @(negedge clk);
        assert (tx_valid != '0) else report_failure("no frame was in flight at the link drop");
        chnl_ready[3] = 1'b0;
        check_quiet(200, 1'b0);
        wait_for_frames(12, 10);
        chnl_ready[3] = 1'b1;
        wait_for_starts(13, 10);
        wait_for_frames(13, SLOT_PERIOD);
        rand_ready_en = 1'b0;

        all_done = 1'b1;
        for (int c = 0; c < CHANNELS; c++) begin
            if (frames_done[c] != start_cnt || exp_q[c].size() != 0) all_done = 1'b0;
        end
        if (all_done) begin
            $display("TEST PASS");
            $finish;
        end else begin
            report_failure("frame count does not match the number of slot starts");
        end
    end

endmodule

`default_nettype wire

// ==== logic/ocs_controller.sv ====
`default_nettype none

module ocs_controller #(
    parameter int                  P_CHANNEL_NUM  = 8,
    parameter ocs_pkg::cycle_cnt_t P_SLOT_LEN     = 32'd2343,
    parameter ocs_pkg::cycle_cnt_t P_CONFIG_DELAY = 32'd234
) (
    input  wire logic                                    i_clk,
    input  wire logic                                    i_reset,
    input  wire logic                [P_CHANNEL_NUM-1:0] i_chnl_ready,
    output wire logic                [P_CHANNEL_NUM-1:0] o_tx_valid,
    output wire ocs_pkg::axis_beat_t [P_CHANNEL_NUM-1:0] o_tx_beat,
    input  wire logic                [P_CHANNEL_NUM-1:0] i_tx_ready,
    output wire logic                                    o_slot_start,
    output wire ocs_pkg::slot_id_t                       o_slot_id
);

    ocs_pkg::slot_event_t w_slot_event;

    assign o_slot_id = w_slot_event.slot_id;

    ocs_slot_timer #(
        .P_CHANNEL_NUM  (P_CHANNEL_NUM),
        .P_SLOT_LEN     (P_SLOT_LEN),
        .P_CONFIG_DELAY (P_CONFIG_DELAY)
    ) u_slot_timer (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_chnl_ready (i_chnl_ready),
        .o_slot_start (o_slot_start),
        .o_slot_event (w_slot_event)
    );

    //////////////////////////////////////////////////
    // One transmitter per ToR link

    for (genvar c = 0; c < P_CHANNEL_NUM; c++) begin : g_chan
        ocs_slot_frame_tx #(
            .P_CHANNEL_IDX (ocs_pkg::chan_idx_t'(c))
        ) u_frame_tx (
            .i_clk        (i_clk),
            .i_reset      (i_reset),
            .i_slot_start (o_slot_start),
            .i_slot_event (w_slot_event),
            .o_tx_valid   (o_tx_valid[c]),
            .o_tx_beat    (o_tx_beat[c]),
            .i_tx_ready   (i_tx_ready[c])
        );
    end

endmodule

`default_nettype wire

// ==== logic/ocs_pkg.sv ====
`default_nettype none

package ocs_pkg;

    //////////////////////////////////////////////////
    // Widths with a meaning

    typedef logic [7:0]  slot_id_t;
    typedef logic [7:0]  chan_idx_t;
    typedef logic [31:0] cycle_cnt_t;
    typedef logic [47:0] mac_t;
    typedef logic [15:0] ether_type_t;
    typedef logic [2:0]  beat_idx_t;

    //////////////////////////////////////////////////
    // Frame fields

    localparam mac_t        CTRL_MAC        = 48'h8DBC5C4A1A1F;
    // Byte 1 is replaced by the channel index
    localparam mac_t        TOR_MAC_BASE    = 48'h8DBC5C4A0000;
    localparam ether_type_t SLOT_ETHER_TYPE = 16'hFF03;
    localparam int          FRAME_BEATS     = 8;

    typedef enum logic [7:0] {
        KIND_START = 8'd1,
        KIND_SYNC  = 8'd2
    } frame_kind_e;

    typedef struct packed {
        frame_kind_e kind;
        slot_id_t    slot_id;
    } slot_event_t;

    // One 64-bit stream beat
    typedef struct packed {
        logic [63:0] data;
        logic [7:0]  keep;
        logic        last;
    } axis_beat_t;

    typedef enum logic [1:0] {
        ST_WAIT_LINK,
        ST_SLOT,
        ST_RECONFIG
    } slot_state_e;

endpackage

`default_nettype wire

// ==== logic/ocs_slot_frame_tx.sv ====
`default_nettype none

module ocs_slot_frame_tx #(
    parameter ocs_pkg::chan_idx_t P_CHANNEL_IDX = 8'd0
) (
    input  wire logic                 i_clk,
    input  wire logic                 i_reset,
    input  wire logic                 i_slot_start,
    input  wire ocs_pkg::slot_event_t i_slot_event,
    output logic                      o_tx_valid,
    output ocs_pkg::axis_beat_t       o_tx_beat,
    input  wire logic                 i_tx_ready
);

    logic                 r_busy;
    ocs_pkg::beat_idx_t   r_beat_idx;
    ocs_pkg::slot_event_t r_event;
    ocs_pkg::mac_t        w_dest_mac;
    logic                 w_load;
    logic                 w_xfer;
    logic                 w_last;

    assign w_dest_mac = {
        ocs_pkg::TOR_MAC_BASE[47:16],
        P_CHANNEL_IDX,
        ocs_pkg::TOR_MAC_BASE[7:0]
    };

    assign w_load = i_slot_start && !r_busy;
    assign w_xfer = r_busy && i_tx_ready;
    assign w_last = (r_beat_idx == ocs_pkg::beat_idx_t'(ocs_pkg::FRAME_BEATS - 1));

    assign o_tx_valid = r_busy;

    //////////////////////////////////////////////////
    // Frame sequencing

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            r_busy     <= 1'b0;
            r_beat_idx <= '0;
        end else if (w_load) begin
            r_busy     <= 1'b1;
            r_beat_idx <= '0;
        end else if (w_xfer) begin
            if (w_last) begin
                r_busy <= 1'b0;
            end
            // Wraps back to beat 0 after the last one
            r_beat_idx <= r_beat_idx + 3'd1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (w_load) begin
            r_event <= i_slot_event;
        end
    end

    //////////////////////////////////////////////////
    // Beat contents

    always_comb begin
        o_tx_beat.keep = '1;
        o_tx_beat.last = w_last;
        case (r_beat_idx)
            ocs_pkg::beat_idx_t'(0): begin
                // Destination, then start of source
                o_tx_beat.data = {w_dest_mac, ocs_pkg::CTRL_MAC[47:32]};
            end
            ocs_pkg::beat_idx_t'(1): begin
                o_tx_beat.data = {
                    ocs_pkg::CTRL_MAC[31:0],
                    ocs_pkg::SLOT_ETHER_TYPE,
                    r_event.slot_id,
                    r_event.kind
                };
            end
            default: begin
                // Padding up to 64 bytes
                o_tx_beat.data = '0;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // Checks

    a_beat_hold: assert property (
        @(posedge i_clk) disable iff (i_reset)
        (o_tx_valid && !i_tx_ready) |=> (o_tx_valid && $stable(o_tx_beat))
    );

    // Slot spacing must leave room for the whole frame
    a_no_event_when_busy: assert property (
        @(posedge i_clk) disable iff (i_reset)
        i_slot_start |-> !r_busy
    );

endmodule

`default_nettype wire

// ==== logic/ocs_slot_timer.sv ====
`default_nettype none

module ocs_slot_timer #(
    parameter int                  P_CHANNEL_NUM  = 8,
    parameter ocs_pkg::cycle_cnt_t P_SLOT_LEN     = 32'd2343,
    parameter ocs_pkg::cycle_cnt_t P_CONFIG_DELAY = 32'd234
) (
    input  wire logic                     i_clk,
    input  wire logic                     i_reset,
    input  wire logic [P_CHANNEL_NUM-1:0] i_chnl_ready,
    output logic                          o_slot_start,
    output ocs_pkg::slot_event_t          o_slot_event
);

    ocs_pkg::slot_state_e r_state;
    ocs_pkg::cycle_cnt_t  r_cycle_cnt;
    logic                 w_all_ready;

    assign w_all_ready = &i_chnl_ready;

    //////////////////////////////////////////////////
    // Slot and reconfiguration sequencing

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            r_state              <= ocs_pkg::ST_WAIT_LINK;
            r_cycle_cnt          <= '0;
            o_slot_start         <= 1'b0;
            o_slot_event.kind    <= ocs_pkg::KIND_START;
            o_slot_event.slot_id <= '0;
        end else if (!w_all_ready) begin
            // Any link down restarts the schedule
            r_state              <= ocs_pkg::ST_WAIT_LINK;
            r_cycle_cnt          <= '0;
            o_slot_start         <= 1'b0;
            o_slot_event.slot_id <= '0;
        end else begin
            o_slot_start <= 1'b0;
            case (r_state)
                ocs_pkg::ST_WAIT_LINK: begin
                    r_state              <= ocs_pkg::ST_SLOT;
                    r_cycle_cnt          <= '0;
                    o_slot_start         <= 1'b1;
                    o_slot_event.kind    <= ocs_pkg::KIND_START;
                    o_slot_event.slot_id <= '0;
                end
                ocs_pkg::ST_SLOT: begin
                    if (r_cycle_cnt == P_SLOT_LEN - 32'd1) begin
                        r_state     <= ocs_pkg::ST_RECONFIG;
                        r_cycle_cnt <= '0;
                    end else begin
                        r_cycle_cnt <= r_cycle_cnt + 32'd1;
                    end
                end
                ocs_pkg::ST_RECONFIG: begin
                    if (r_cycle_cnt == P_CONFIG_DELAY - 32'd1) begin
                        // Switch settled, open the next slot
                        r_state              <= ocs_pkg::ST_SLOT;
                        r_cycle_cnt          <= '0;
                        o_slot_start         <= 1'b1;
                        o_slot_event.kind    <= ocs_pkg::KIND_SYNC;
                        o_slot_event.slot_id <= o_slot_event.slot_id + 8'd1;
                    end else begin
                        r_cycle_cnt <= r_cycle_cnt + 32'd1;
                    end
                end
                default: begin
                    r_state <= ocs_pkg::ST_WAIT_LINK;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Checks

    a_start_single_cycle: assert property (
        @(posedge i_clk) disable iff (i_reset)
        o_slot_start |=> !o_slot_start
    );

    // First event after a link outage restarts at slot 0
    a_no_event_link_down: assert property (
        @(posedge i_clk) disable iff (i_reset)
        (w_all_ready && !$past(w_all_ready)) |=> (o_slot_start
            && o_slot_event.kind == ocs_pkg::KIND_START
            && o_slot_event.slot_id == '0)
    );

endmodule

`default_nettype wire
